// ==== common/decode_pkg.sv ====
// RV32IM decode types; micro_op_e must fit 6 bits and OP_ILLEGAL must stay at encoding zero
`default_nettype none

package decode_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;

    typedef enum logic [5:0] {
        OP_ILLEGAL = 6'd0,
        // register-register ALU
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        // RV32M group
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU,
        // register-immediate ALU
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        // loads and stores
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        // branches
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        // jumps, upper immediates and system
        OP_JAL, OP_JALR, OP_LUI, OP_AUIPC,
        OP_ECALL, OP_EBREAK
    } micro_op_e;

    // NONE yields a zero immediate
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    // combinational result of the decoder
    typedef struct packed {
        micro_op_e op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     imm;
    } decode_out_t;

    // record handed to execute
    typedef struct packed {
        micro_op_e op;
        reg_addr_t rd;
        xlen_t     imm;
        xlen_t     rs1_val;
        xlen_t     rs2_val;
    } stage_out_t;

    // write-back from the last stage
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        xlen_t     data;
    } wb_t;

endpackage

`default_nettype wire

// ==== decode/instr_decoder.sv ====
// purely combinational; RV32IM only, an illegal word comes out as an all-zero record with op ILLEGAL
`timescale 1ns/100ps
`default_nettype none

module instr_decoder #(
    parameter int NUM_REGS = 32
) (
    input  decode_pkg::instr_t      instr_i,
    output decode_pkg::decode_out_t dec_o
);
    import decode_pkg::*;

    micro_op_e op;
    imm_fmt_e  fmt;
    logic      use_rd;
    logic      use_rs1;
    logic      use_rs2;
    logic      bad_reg;
    xlen_t     imm;

    reg_addr_t rd_f;
    reg_addr_t rs1_f;
    reg_addr_t rs2_f;

    assign rd_f  = instr_i[11:7];
    assign rs1_f = instr_i[19:15];
    assign rs2_f = instr_i[24:20];

    // pattern match on the whole word, fields laid out as funct7_rs2_rs1_funct3_rd_opcode
    always_comb begin
        casez (instr_i)
            32'b0000000_?????_?????_000_?????_0110011: op = OP_ADD;
            32'b0100000_?????_?????_000_?????_0110011: op = OP_SUB;
            32'b0000000_?????_?????_001_?????_0110011: op = OP_SLL;
            32'b0000000_?????_?????_010_?????_0110011: op = OP_SLT;
            32'b0000000_?????_?????_011_?????_0110011: op = OP_SLTU;
            32'b0000000_?????_?????_100_?????_0110011: op = OP_XOR;
            32'b0000000_?????_?????_101_?????_0110011: op = OP_SRL;
            32'b0100000_?????_?????_101_?????_0110011: op = OP_SRA;
            32'b0000000_?????_?????_110_?????_0110011: op = OP_OR;
            32'b0000000_?????_?????_111_?????_0110011: op = OP_AND;
            32'b0000001_?????_?????_000_?????_0110011: op = OP_MUL;
            32'b0000001_?????_?????_001_?????_0110011: op = OP_MULH;
            32'b0000001_?????_?????_010_?????_0110011: op = OP_MULHSU;
            32'b0000001_?????_?????_011_?????_0110011: op = OP_MULHU;
            32'b0000001_?????_?????_100_?????_0110011: op = OP_DIV;
            32'b0000001_?????_?????_101_?????_0110011: op = OP_DIVU;
            32'b0000001_?????_?????_110_?????_0110011: op = OP_REM;
            32'b0000001_?????_?????_111_?????_0110011: op = OP_REMU;
            32'b????????????_?????_000_?????_0010011:  op = OP_ADDI;
            32'b????????????_?????_010_?????_0010011:  op = OP_SLTI;
            32'b????????????_?????_011_?????_0010011:  op = OP_SLTIU;
            32'b????????????_?????_100_?????_0010011:  op = OP_XORI;
            32'b????????????_?????_110_?????_0010011:  op = OP_ORI;
            32'b????????????_?????_111_?????_0010011:  op = OP_ANDI;
            32'b0000000_?????_?????_001_?????_0010011: op = OP_SLLI;
            32'b0000000_?????_?????_101_?????_0010011: op = OP_SRLI;
            32'b0100000_?????_?????_101_?????_0010011: op = OP_SRAI;
            32'b????????????_?????_000_?????_0000011:  op = OP_LB;
            32'b????????????_?????_001_?????_0000011:  op = OP_LH;
            32'b????????????_?????_010_?????_0000011:  op = OP_LW;
            32'b????????????_?????_100_?????_0000011:  op = OP_LBU;
            32'b????????????_?????_101_?????_0000011:  op = OP_LHU;
            32'b???????_?????_?????_000_?????_0100011: op = OP_SB;
            32'b???????_?????_?????_001_?????_0100011: op = OP_SH;
            32'b???????_?????_?????_010_?????_0100011: op = OP_SW;
            32'b???????_?????_?????_000_?????_1100011: op = OP_BEQ;
            32'b???????_?????_?????_001_?????_1100011: op = OP_BNE;
            32'b???????_?????_?????_100_?????_1100011: op = OP_BLT;
            32'b???????_?????_?????_101_?????_1100011: op = OP_BGE;
            32'b???????_?????_?????_110_?????_1100011: op = OP_BLTU;
            32'b???????_?????_?????_111_?????_1100011: op = OP_BGEU;
            32'b????????????????????_?????_1101111:    op = OP_JAL;
            32'b????????????_?????_000_?????_1100111:  op = OP_JALR;
            32'b????????????????????_?????_0110111:    op = OP_LUI;
            32'b????????????????????_?????_0010111:    op = OP_AUIPC;
            32'b000000000000_00000_000_00000_1110011:  op = OP_ECALL;
            32'b000000000001_00000_000_00000_1110011:  op = OP_EBREAK;
            default:                                   op = OP_ILLEGAL;
        endcase
    end

    // format and register use follow from the opcode alone
    always_comb begin
        fmt     = IMM_NONE;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (instr_i[6:0])
            7'b0110011: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            7'b0010011, 7'b0000011, 7'b1100111: begin
                fmt     = IMM_I;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            7'b0100011: begin
                fmt     = IMM_S;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            7'b1100011: begin
                fmt     = IMM_B;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            7'b0110111, 7'b0010111: begin
                fmt    = IMM_U;
                use_rd = 1'b1;
            end
            7'b1101111: begin
                fmt    = IMM_J;
                use_rd = 1'b1;
            end
            default: begin
                fmt = IMM_NONE;
            end
        endcase
    end

    // sign always comes from bit 31
    always_comb begin
        case (fmt)
            IMM_I:   imm = {{20{instr_i[31]}}, instr_i[31:20]};
            IMM_S:   imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B:   imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                            instr_i[30:25], instr_i[11:8], 1'b0};
            IMM_U:   imm = {instr_i[31:12], 12'd0};
            IMM_J:   imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                            instr_i[20], instr_i[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // only indices the format actually uses can make the word illegal
    assign bad_reg = (use_rd  && (32'(rd_f)  >= NUM_REGS)) ||
                     (use_rs1 && (32'(rs1_f) >= NUM_REGS)) ||
                     (use_rs2 && (32'(rs2_f) >= NUM_REGS));

    always_comb begin
        dec_o = '0;
        if (op != OP_ILLEGAL && !bad_reg) begin
            dec_o.op  = op;
            dec_o.rd  = use_rd  ? rd_f  : '0;
            dec_o.rs1 = use_rs1 ? rs1_f : '0;
            dec_o.rs2 = use_rs2 ? rs2_f : '0;
            dec_o.imm = imm;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// NUM_REGS must be a power of two; write-back addresses at or above NUM_REGS alias by low bits
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  decode_pkg::reg_addr_t rd1_addr_i,
    input  decode_pkg::reg_addr_t rd2_addr_i,
    output decode_pkg::xlen_t     rd1_data_o,
    output decode_pkg::xlen_t     rd2_data_o,
    input  decode_pkg::wb_t       wb_i
);
    import decode_pkg::*;

    localparam int AW = $clog2(NUM_REGS);

    xlen_t regs [NUM_REGS];

    logic [AW-1:0] wr_idx;
    logic [AW-1:0] rd1_idx;
    logic [AW-1:0] rd2_idx;

    assign wr_idx  = wb_i.addr[AW-1:0];
    assign rd1_idx = rd1_addr_i[AW-1:0];
    assign rd2_idx = rd2_addr_i[AW-1:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.en && wr_idx != '0) begin
            regs[wr_idx] <= wb_i.data;
        end
    end

    // x0 is forced to zero on the read side as well
    assign rd1_data_o = (rd1_idx == '0) ? '0 : regs[rd1_idx];
    assign rd2_data_o = (rd2_idx == '0) ? '0 : regs[rd2_idx];

endmodule

`default_nettype wire

// ==== rtl/operand_stage.sv ====
// one register level, no back-pressure; payload fields only load on a strobe and hold otherwise
`timescale 1ns/100ps
`default_nettype none

module operand_stage (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    valid_i,
    input  decode_pkg::decode_out_t dec_i,
    input  decode_pkg::xlen_t       rs1_raw_i,
    input  decode_pkg::xlen_t       rs2_raw_i,
    input  decode_pkg::wb_t         wb_i,
    output decode_pkg::stage_out_t  out_o,
    output logic                    out_valid_o
);
    import decode_pkg::*;

    logic  fwd_rs1;
    logic  fwd_rs2;
    xlen_t rs1_val;
    xlen_t rs2_val;

    // a write landing this cycle is not yet visible in the array
    assign fwd_rs1 = wb_i.en && (wb_i.addr != '0) && (wb_i.addr == dec_i.rs1);
    assign fwd_rs2 = wb_i.en && (wb_i.addr != '0) && (wb_i.addr == dec_i.rs2);

    assign rs1_val = fwd_rs1 ? wb_i.data : rs1_raw_i;
    assign rs2_val = fwd_rs2 ? wb_i.data : rs2_raw_i;

    // control part of the record
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
            out_o.op    <= OP_ILLEGAL;
        end else begin
            out_valid_o <= valid_i;
            if (valid_i) begin
                out_o.op <= dec_i.op;
            end
        end
    end

    // payload part
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            out_o.rd      <= dec_i.rd;
            out_o.imm     <= dec_i.imm;
            out_o.rs1_val <= rs1_val;
            out_o.rs2_val <= rs2_val;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_read_top.sv ====
// decode and register read, one cycle strobe to record; execute must take a record every cycle
`timescale 1ns/100ps
`default_nettype none

module decode_read_top #(
    parameter int NUM_REGS = 32
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  decode_pkg::instr_t     instr_i,
    input  logic                   instr_valid_i,
    input  decode_pkg::wb_t        wb_i,
    output decode_pkg::stage_out_t out_o,
    output logic                   out_valid_o
);
    import decode_pkg::*;

    decode_out_t dec;
    xlen_t       rs1_raw;
    xlen_t       rs2_raw;

    instr_decoder #(
        .NUM_REGS (NUM_REGS)
    ) u_decoder (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    // reads run in parallel with the decode, on the zeroed fields of unused slots
    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd1_addr_i (dec.rs1),
        .rd2_addr_i (dec.rs2),
        .rd1_data_o (rs1_raw),
        .rd2_data_o (rs2_raw),
        .wb_i       (wb_i)
    );

    operand_stage u_stage (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (instr_valid_i),
        .dec_i       (dec),
        .rs1_raw_i   (rs1_raw),
        .rs2_raw_i   (rs2_raw),
        .wb_i        (wb_i),
        .out_o       (out_o),
        .out_valid_o (out_valid_o)
    );

endmodule

`default_nettype wire

// ==== testbench/decode_read_assertions.sv ====
// bound into operand_stage; single clock, synchronous active-high reset
`timescale 1ns/100ps
`default_nettype none

module decode_read_assertions (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    valid_i,
    input decode_pkg::decode_out_t dec_i,
    input decode_pkg::stage_out_t  out_i,
    input logic                    out_valid_i
);

    int fail_count = 0;

    // nothing valid right after a reset cycle
    reset_clears_valid: assert property (@(posedge clk_i) rst_i |=> !out_valid_i)
        else begin
            fail_count++;
            $error("out_valid_o high in the cycle after reset");
        end

    // valid is the strobe one cycle late
    valid_follows_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
        1'b1 |=> (out_valid_i == $past(valid_i)))
        else begin
            fail_count++;
            $error("out_valid_o does not follow valid_i by one cycle");
        end

    // x0 as a source reads zero even with a write-back in flight
    x0_rs1_not_forwarded: assert property (@(posedge clk_i) disable iff (rst_i)
        (valid_i && dec_i.rs1 == '0) |=> (out_i.rs1_val == '0))
        else begin
            fail_count++;
            $error("rs1_val nonzero for a read of x0");
        end

    x0_rs2_not_forwarded: assert property (@(posedge clk_i) disable iff (rst_i)
        (valid_i && dec_i.rs2 == '0) |=> (out_i.rs2_val == '0))
        else begin
            fail_count++;
            $error("rs2_val nonzero for a read of x0");
        end

endmodule

bind operand_stage decode_read_assertions u_assertions (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .dec_i       (dec_i),
    .out_i       (out_o),
    .out_valid_i (out_valid_o)
);

`default_nettype wire

// ==== testbench/tb_decode_read.sv ====
// NUM_REGS fixed at 32; each record is checked one cycle after its strobe against the model below
`timescale 1ns/100ps
`default_nettype none

module tb_decode_read;
    import decode_pkg::*;

    localparam int NUM_REGS = 32;
    localparam int TIMEOUT  = 16;

    logic       clk_i;
    logic       rst_i;
    instr_t     instr_i;
    logic       instr_valid_i;
    wb_t        wb_i;
    stage_out_t out_o;
    logic       out_valid_o;

    logic [15:0] lfsr;
    xlen_t       model_regs [NUM_REGS];
    logic        exp_valid;
    stage_out_t  exp_rec;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          sent;
    int          seen;

    decode_read_top #(.NUM_REGS(NUM_REGS)) uut (.*);

    always #20 clk_i = ~clk_i;

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic wb_t random_wb();
        wb_t wb;
        wb.en   = rand_bits(1) != 0;
        wb.addr = reg_addr_t'(rand_bits(5));
        wb.data = rand_bits(32);
        return wb;
    endfunction

    // legal opcode templates with random fields, codes 13 to 15 stay fully random
    function automatic instr_t random_instr();
        instr_t     w;
        logic [3:0] pick;
        logic [1:0] f7_pick;
        w       = rand_bits(32);
        pick    = 4'(rand_bits(4));
        f7_pick = 2'(rand_bits(2));
        case (pick)
            0, 1, 2: w[6:0] = 7'b0110011;
            3, 4:    w[6:0] = 7'b0010011;
            5:       w[6:0] = 7'b0000011;
            6:       w[6:0] = 7'b0100011;
            7:       w[6:0] = 7'b1100011;
            8:       w[6:0] = 7'b1101111;
            9:       w[6:0] = 7'b1100111;
            10:      w[6:0] = 7'b0110111;
            11:      w[6:0] = 7'b0010111;
            12:      w = f7_pick[0] ? 32'h0010_0073 : 32'h0000_0073;
            default: ;
        endcase
        // register forms and immediate shifts mostly get a legal funct7
        if (pick < 3 || (pick < 5 && w[13:12] == 2'b01)) begin
            w[31:25] = (f7_pick == 2'd1) ? 7'h20 : (f7_pick == 2'd2) ? 7'h01 : 7'h00;
        end
        if (pick == 4'd9 && f7_pick != 2'd3) begin
            w[14:12] = 3'b000;
        end
        return w;
    endfunction

    // reference decode from the RV32IM opcode tables; uses holds rd, rs1, rs2
    function automatic decode_out_t model_decode(input instr_t w);
        decode_out_t d;
        micro_op_e   op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [2:0]  uses;
        xlen_t       imm;
        f3   = w[14:12];
        f7   = w[31:25];
        op   = OP_ILLEGAL;
        uses = 3'b000;
        imm  = '0;
        case (w[6:0])
            7'b0110011: begin
                uses = 3'b111;
                if (f7 == 7'h01) begin
                    op = micro_op_e'(OP_MUL + 6'(f3));
                end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    case (f3)
                        3'd0: op = f7[5] ? OP_SUB : OP_ADD;
                        3'd1: op = OP_SLL;
                        3'd2: op = OP_SLT;
                        3'd3: op = OP_SLTU;
                        3'd4: op = OP_XOR;
                        3'd5: op = f7[5] ? OP_SRA : OP_SRL;
                        3'd6: op = OP_OR;
                        default: op = OP_AND;
                    endcase
                end
            end
            7'b0010011: begin
                uses = 3'b110;
                imm  = xlen_t'($signed(w) >>> 20);
                case (f3)
                    3'd0: op = OP_ADDI;
                    3'd1: op = (f7 == 7'h00) ? OP_SLLI : OP_ILLEGAL;
                    3'd2: op = OP_SLTI;
                    3'd3: op = OP_SLTIU;
                    3'd4: op = OP_XORI;
                    3'd5: op = (f7 == 7'h00) ? OP_SRLI : (f7 == 7'h20) ? OP_SRAI : OP_ILLEGAL;
                    3'd6: op = OP_ORI;
                    default: op = OP_ANDI;
                endcase
            end
            7'b0000011: begin
                uses = 3'b110;
                imm  = xlen_t'($signed(w) >>> 20);
                if (f3 < 3'd3) op = micro_op_e'(OP_LB + 6'(f3));
                else if (f3 == 3'd4 || f3 == 3'd5) op = micro_op_e'(OP_LBU + 6'(f3 - 3'd4));
            end
            7'b0100011: begin
                uses = 3'b011;
                imm  = xlen_t'($signed({w[31:25], w[11:7], 20'd0}) >>> 20);
                if (f3 < 3'd3) op = micro_op_e'(OP_SB + 6'(f3));
            end
            7'b1100011: begin
                uses = 3'b011;
                imm  = xlen_t'($signed({w[31], w[7], w[30:25], w[11:8], 20'd0}) >>> 19);
                if (f3 < 3'd2) op = micro_op_e'(OP_BEQ + 6'(f3));
                else if (f3 > 3'd3) op = micro_op_e'(OP_BLT + 6'(f3 - 3'd4));
            end
            7'b1101111: begin
                uses = 3'b100;
                imm  = xlen_t'($signed({w[31], w[19:12], w[20], w[30:21], 12'd0}) >>> 11);
                op   = OP_JAL;
            end
            7'b1100111: begin
                uses = 3'b110;
                imm  = xlen_t'($signed(w) >>> 20);
                if (f3 == 3'd0) op = OP_JALR;
            end
            7'b0110111, 7'b0010111: begin
                uses = 3'b100;
                imm  = {w[31:12], 12'd0};
                op   = w[5] ? OP_LUI : OP_AUIPC;
            end
            7'b1110011: begin
                if (w == 32'h0000_0073) op = OP_ECALL;
                if (w == 32'h0010_0073) op = OP_EBREAK;
            end
            default: ;
        endcase
        // an index the file does not hold makes the word illegal too
        if ((uses[2] && 32'(w[11:7]) >= NUM_REGS) || (uses[1] && 32'(w[19:15]) >= NUM_REGS) ||
            (uses[0] && 32'(w[24:20]) >= NUM_REGS)) begin
            op = OP_ILLEGAL;
        end
        d = '0;
        if (op != OP_ILLEGAL) begin
            d.op  = op;
            d.rd  = uses[2] ? w[11:7] : '0;
            d.rs1 = uses[1] ? w[19:15] : '0;
            d.rs2 = uses[0] ? w[24:20] : '0;
            d.imm = imm;
        end
        return d;
    endfunction

    // same-cycle write-back wins over the stored value
    function automatic xlen_t model_read(input reg_addr_t a, input wb_t wb);
        if (a == '0) return '0;
        if (wb.en && wb.addr == a) return wb.data;
        return model_regs[a];
    endfunction

    task automatic predict(input instr_t w, input logic v, input wb_t wb);
        decode_out_t d;
        d = model_decode(w);
        exp_valid = v;
        if (v) begin
            exp_rec.op      = d.op;
            exp_rec.rd      = d.rd;
            exp_rec.imm     = d.imm;
            exp_rec.rs1_val = model_read(d.rs1, wb);
            exp_rec.rs2_val = model_read(d.rs2, wb);
            sent++;
        end
        if (wb.en && wb.addr != '0) model_regs[wb.addr] = wb.data;
    endtask

    task automatic check_op(input string name, input micro_op_e got, input micro_op_e exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // payload only counts when a record is expected, op holds in between
    task automatic check_record();
        if (out_valid_o === 1'b1) seen++;
        check_valid("out_valid_o", out_valid_o, exp_valid);
        check_op("out_o.op", out_o.op, exp_rec.op);
        if (exp_valid) begin
            check_addr("out_o.rd", out_o.rd, exp_rec.rd);
            check_word("out_o.imm", out_o.imm, exp_rec.imm);
            check_word("out_o.rs1_val", out_o.rs1_val, exp_rec.rs1_val);
            check_word("out_o.rs2_val", out_o.rs2_val, exp_rec.rs2_val);
        end
    endtask

    // drive on the rising edge, check the previous item at the falling edge
    task automatic step(input instr_t w, input logic v, input wb_t wb);
        @(posedge clk_i);
        instr_i       <= w;
        instr_valid_i <= v;
        wb_i          <= wb;
        @(negedge clk_i);
        check_record();
        predict(w, v, wb);
    endtask

    // one strobe, then poll for its record
    task automatic wait_record(input instr_t w);
        int waited;
        waited = 0;
        step(w, 1'b1, '0);
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (out_valid_o !== 1'b1 && waited < TIMEOUT);
        if (out_valid_o !== 1'b1) begin
            $display("Timeout: no record came out within %0d cycles of the strobe", TIMEOUT);
            errors++;
        end else if (waited != 1) begin
            $display("Record came out %0d cycles after the strobe instead of one", waited);
            errors++;
        end
        check_record();
        predict(w, 1'b0, '0);
    endtask

    task automatic report(input string name, input int start);
        tests_run++;
        if (errors != start) tests_failed++;
        $display("%s: %s, %0d errors", name, (errors == start) ? "passed" : "failed",
                 errors - start);
    endtask

    initial begin
        wb_t    wb;
        instr_t w;
        logic   v;
        int     start;
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        wb_i          = '0;
        lfsr          = 16'd54962;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        sent          = 0;
        seen          = 0;
        exp_valid     = 1'b0;
        exp_rec       = '0;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;

        // idle after reset, first record, then every register reads zero
        start = errors;
        for (int i = 0; i < 4; i++) step('0, 1'b0, '0);
        wait_record(32'h0000_0033);
        for (int i = 0; i < NUM_REGS; i++) begin
            step({7'h00, 5'(31 - i), 5'(i), 3'd0, 5'd1, 7'b0110011}, 1'b1, '0);
        end
        report("reset", start);

        start = errors;
        for (int i = 0; i < 400; i++) begin
            w  = random_instr();
            wb = random_wb();
            step(w, 1'b1, wb);
        end
        report("decode_imm_operands", start);

        // write-back aimed at a source of an ADD-family word
        start = errors;
        for (int i = 0; i < 64; i++) begin
            w        = rand_bits(32);
            w[31:25] = 7'h00;
            w[6:0]   = 7'b0110011;
            wb       = random_wb();
            wb.en    = 1'b1;
            wb.addr  = i[0] ? w[24:20] : w[19:15];
            step(w, 1'b1, wb);
        end
        report("forwarding", start);

        start = errors;
        for (int i = 0; i < 32; i++) begin
            w         = random_instr();
            w[19:15]  = 5'd0;
            wb        = random_wb();
            wb.en     = 1'b1;
            wb.addr   = '0;
            step(w, 1'b1, wb);
        end
        report("x0", start);

        start = errors;
        for (int i = 0; i < 300; i++) begin
            w  = random_instr();
            v  = rand_bits(2) != 0;
            wb = random_wb();
            step(w, v, wb);
        end
        step('0, 1'b0, '0);
        if (seen != sent) begin
            $display("Lost or repeated records: %0d strobes gave %0d records", sent, seen);
            errors++;
        end
        report("streaming", start);

        errors += uut.u_stage.u_assertions.fail_count;
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
common/decode_pkg.sv
decode/instr_decoder.sv
rtl/reg_file.sv
rtl/operand_stage.sv
rtl/decode_read_top.sv
testbench/decode_read_assertions.sv
testbench/tb_decode_read.sv
